//--- src.f
+incdir+source
source/bk_pkg.sv
source/bk_save_tracker.sv
source/bk_buffer_ram.sv
source/bk_block_mover.sv
source/bk_sequencer.sv
source/bk_engine_top.sv
bench/bk_engine_assert.sv
bench/bk_engine_tb.sv

//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -j 0 --top-module bk_engine_tb -Mdir obj_dir -f src.f

run: compile
	./obj_dir/Vbk_engine_tb > sim.log 2>&1 || true
	cat sim.log
	! grep -q "Verification failed" sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bench/bk_engine_tb.sv
// ====================
// Testbench of the backup RAM engine with SD host and SDRAM models
// Runs save and load sequences on LFSR data and checks them word by word
// ====================
`timescale 1ns/1ps
`include "bk_macros.svh"

module bk_engine_tb;
	import bk_pkg::*;

	localparam int TIMEOUT = 5000; // Cycles allowed for each wait
	localparam int QUIET   = 2000; // Window where no sequence may start

	logic                  clk_sys;
	logic                  arst_n;
	logic                  bk_load;
	logic                  bk_save;
	save_kind_t            save_kind;
	logic                  bus_req;
	logic                  flash_1m;
	logic                  cart_load;
	sd_cmd_t               sd_cmd;
	logic                  sd_ack;
	sd_buf_t               sd_buf;
	logic [`BK_WORD_W-1:0] sd_buf_q;
	mem_req_t              mem_req;
	mem_rsp_t              mem_rsp = '0;
	logic                  busy;
	logic                  pending;

	logic [`BK_WORD_W-1:0] sd_img  [1 << `BK_MEM_ADDR_W]; // SD card image by sector then word
	logic [`BK_WORD_W-1:0] sdram_q [1 << `BK_MEM_ADDR_W]; // SDRAM model contents
	logic [15:0]           host_lfsr = 16'd30026;         // Host data and ack delays
	logic [15:0]           mem_lfsr  = 16'd30026;         // SDRAM fill and ready delays
	logic [15:0]           mem_wait;
	logic                  mem_busy;
	string                 test_name;

	bk_engine_top i_bk_engine_top (.*); // Port names match one to one

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// Fibonacci LFSR stepped once per bit taken
	function automatic logic [15:0] lfsr_take(inout logic [15:0] state, input int nbits);
		logic [15:0] val;
		logic        fb;
		int          i;
		val = '0;
		for (i = 0; i < nbits; i++) begin
			fb    = state[15] ^ state[13] ^ state[12] ^ state[10]; // Taps 16 14 13 11
			state = {state[14:0], fb};
			val   = {val[14:0], fb};
		end
		return val;
	endfunction

	task automatic check_value(input string what, input logic [31:0] exp,
			input logic [31:0] act);
		assert (exp == act) else begin
			$display("[FAIL] %s: %s expected 0x%0h actual 0x%0h", test_name, what, exp, act);
			$display("Verification failed");
			$fatal(1);
		end
	endtask

	// One cycle of a bounded wait
	task automatic step_or_timeout(inout int n, input string what);
		if (n == TIMEOUT) begin
			$display("[FAIL] %s: no %s within %0d cycles", test_name, what, TIMEOUT);
			$display("Verification failed");
			$fatal(1);
		end
		n++;
		@(negedge clk_sys);
	endtask

	task automatic random_delay();
		logic [15:0] n;
		n = lfsr_take(host_lfsr, 2); // 0 to 3 cycles
		repeat (n) @(negedge clk_sys);
	endtask

	// SD host model fills the buffer on a read and checks it against SDRAM on a write
	task automatic serve_sector(input logic is_wr, input logic [`BK_LBA_W-1:0] lba);
		int          n;
		logic [15:0] addr;
		n = 0;
		while (!(is_wr ? sd_cmd.wr : sd_cmd.rd))
			step_or_timeout(n, "SD sector request");
		check_value("sector lba", 32'(lba), 32'(sd_cmd.lba));
		random_delay();
		sd_ack = 1'b1;
		for (n = 0; n < 256; n++) begin
			addr   = {lba, n[7:0]};
			sd_buf = '{addr: n[7:0], din: sd_img[addr], wr: !is_wr};
			@(negedge clk_sys); // Registered read lands here
			if (is_wr)
				check_value("sector word", 32'(sdram_q[addr]), 32'(sd_buf_q));
		end
		sd_buf.wr = 1'b0;
		check_value("request after ack", 0, 32'({sd_cmd.rd, sd_cmd.wr}));
		random_delay();
		sd_ack = 1'b0; // Sector complete
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (busy)
			step_or_timeout(n, "end of sequence");
	endtask

	task automatic expect_quiet();
		int n;
		for (n = 0; n < QUIET; n++) begin
			@(negedge clk_sys);
			check_value("sd request or busy", 0, 32'({sd_cmd.rd, sd_cmd.wr, busy}));
		end
	endtask

	task automatic raise_edge(input logic is_save);
		bk_load = !is_save;
		bk_save = is_save;
		repeat (4) @(negedge clk_sys);
		bk_load = 1'b0;
		bk_save = 1'b0;
	endtask

	// One cartridge save access
	task automatic write_save(input save_kind_t kind, input logic big);
		save_kind = kind;
		flash_1m  = big;
		bus_req   = 1'b1;
		@(negedge clk_sys);
		bus_req   = 1'b0;
		save_kind = '0;
		@(negedge clk_sys);
	endtask

	// ====================
	// SDRAM model
	// ====================
	initial begin
		int i;
		for (i = 0; i < (1 << `BK_MEM_ADDR_W); i++)
			sdram_q[i[15:0]] = lfsr_take(mem_lfsr, 16);
		mem_busy = 1'b0;
		mem_wait = '0;
		forever begin
			@(negedge clk_sys);
			mem_rsp.ready = 1'b0; // Ready is one cycle wide
			if (mem_busy) begin
				if (mem_wait == '0) begin
					mem_rsp.ready = 1'b1;
					mem_busy      = 1'b0;
				end else
					mem_wait = mem_wait - 1'b1;
			end else if (mem_req.req) begin
				if (mem_req.rnw)
					mem_rsp.dout = sdram_q[mem_req.addr];
				else
					sdram_q[mem_req.addr] = mem_req.din;
				mem_wait = lfsr_take(mem_lfsr, 2);
				mem_busy = 1'b1;
			end
		end
	end

	// Bound protocol assertions count their failures
	always @(i_bk_engine_top.i_bk_engine_assert.fail_count) begin
		assert (i_bk_engine_top.i_bk_engine_assert.fail_count == 0) else begin
			$display("[FAIL] %s: an SD or SDRAM protocol assertion failed", test_name);
			$display("Verification failed");
			$fatal(1);
		end
	end

	// ====================
	// Test sequence
	// ====================
	initial begin
		int i;
		int s;
		arst_n    = 1'b0;
		bk_load   = 1'b0;
		bk_save   = 1'b0;
		save_kind = '0;
		bus_req   = 1'b0;
		flash_1m  = 1'b0;
		cart_load = 1'b0;
		sd_ack    = 1'b0;
		sd_buf    = '0;
		test_name = "reset";
		repeat (16) @(negedge clk_sys);
		arst_n = 1'b1;
		@(negedge clk_sys);
		check_value("outputs", 0, 32'({sd_cmd.rd, sd_cmd.wr, mem_req.req, busy, pending}));
		raise_edge(1'b1); // Nothing pending
		expect_quiet();

		test_name = "eeprom save";
		write_save('{eeprom: 1'b1, sram: 1'b0, flash: 1'b0}, 1'b0);
		check_value("pending", 1, 32'(pending));
		raise_edge(1'b1);
		for (s = 0; s < 16; s++)
			serve_sector(1'b1, s[7:0]);
		wait_idle();
		check_value("pending", 0, 32'(pending));
		expect_quiet(); // No sector past 15

		test_name = "flash 1m save";
		write_save('{eeprom: 1'b0, sram: 1'b1, flash: 1'b0}, 1'b0);
		write_save('{eeprom: 1'b0, sram: 1'b0, flash: 1'b1}, 1'b1);
		raise_edge(1'b1);
		for (s = 0; s < 256; s++)
			serve_sector(1'b1, s[7:0]);
		wait_idle();
		raise_edge(1'b1); // Pending already cleared
		expect_quiet();

		test_name = "full load";
		for (i = 0; i < (1 << `BK_MEM_ADDR_W); i++)
			sd_img[i[15:0]] = lfsr_take(host_lfsr, 16);
		raise_edge(1'b0);
		for (s = 0; s < 256; s++)
			serve_sector(1'b0, s[7:0]);
		wait_idle();
		for (i = 0; i < (1 << `BK_MEM_ADDR_W); i++)
			check_value("sdram word", 32'(sd_img[i[15:0]]), 32'(sdram_q[i[15:0]]));

		test_name = "cart load";
		write_save('{eeprom: 1'b1, sram: 1'b0, flash: 1'b0}, 1'b0); // Leaves a save pending
		cart_load = 1'b1;
		@(negedge clk_sys);
		cart_load = 1'b0;
		raise_edge(1'b0);
		expect_quiet();
		check_value("pending", 1, 32'(pending));
		raise_edge(1'b1); // Pending but no size
		expect_quiet();

		$display("Verification passed");
		$finish;
	end

endmodule

//--- bench/bk_engine_assert.sv
// ====================
// SD and SDRAM protocol assertions, bound to the engine top
// ====================
`timescale 1ns/1ps

module bk_engine_assert (
	input logic              clk_sys,
	input logic              arst_n,
	input bk_pkg::sd_cmd_t   sd_cmd,
	input bk_pkg::mem_req_t  mem_req,
	input logic              xfer_start
);

	int fail_count = 0; // Failed assertion count

	// Request strobe lasts one cycle
	req_one_cycle: assert property (@(posedge clk_sys) disable iff (!arst_n)
		mem_req.req |=> !mem_req.req)
		else begin
			$error("SDRAM req held for more than one cycle");
			fail_count++;
		end

	rd_wr_exclusive: assert property (@(posedge clk_sys) disable iff (!arst_n)
		!(sd_cmd.rd && sd_cmd.wr))
		else begin
			$error("SD rd and wr high together");
			fail_count++;
		end

	req_in_xfer: assert property (@(posedge clk_sys) disable iff (!arst_n)
		mem_req.req |-> xfer_start) // Mover idle outside a transfer
		else begin
			$error("SDRAM req issued while xfer_start is low");
			fail_count++;
		end

endmodule

bind bk_engine_top bk_engine_assert i_bk_engine_assert (
	.clk_sys    (clk_sys),
	.arst_n     (arst_n),
	.sd_cmd     (sd_cmd),
	.mem_req    (mem_req),
	.xfer_start (xfer_start)
);

//--- source/bk_engine_top.sv
// ====================
// Backup RAM engine top, SD sector buffer to SDRAM and back
// ====================
`timescale 1ns/1ps
`include "bk_macros.svh"

module bk_engine_top (
	input  logic                  clk_sys,
	input  logic                  arst_n,
	input  logic                  bk_load,
	input  logic                  bk_save,
	input  bk_pkg::save_kind_t    save_kind,
	input  logic                  bus_req,
	input  logic                  flash_1m,
	input  logic                  cart_load,
	output bk_pkg::sd_cmd_t       sd_cmd,    // SD host side
	input  logic                  sd_ack,
	input  bk_pkg::sd_buf_t       sd_buf,
	output logic [`BK_WORD_W-1:0] sd_buf_q,
	output bk_pkg::mem_req_t      mem_req,   // SDRAM channel
	input  bk_pkg::mem_rsp_t      mem_rsp,
	output logic                  busy,      // Sequence running
	output logic                  pending    // Unsaved writes
);
	import bk_pkg::*;

	logic [`BK_LBA_W-1:0] save_sz;
	logic                 xfer_start;
	logic                 xfer_done;
	bk_mode_e             mode;

	bk_save_tracker i_bk_save_tracker (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.save_kind (save_kind),
		.bus_req   (bus_req),
		.flash_1m  (flash_1m),
		.cart_load (cart_load),
		.busy      (busy),
		.save_sz   (save_sz),
		.pending   (pending)
	);

	bk_sequencer i_bk_sequencer (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.bk_load    (bk_load),
		.bk_save    (bk_save),
		.pending    (pending),
		.save_sz    (save_sz),
		.sd_ack     (sd_ack),
		.sd_cmd     (sd_cmd),
		.xfer_start (xfer_start),
		.mode       (mode),
		.xfer_done  (xfer_done),
		.busy       (busy)
	);

	// Sector address comes straight from the SD command
	bk_block_mover i_bk_block_mover (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.xfer_start (xfer_start),
		.mode       (mode),
		.lba        (sd_cmd.lba),
		.mem_req    (mem_req),
		.mem_rsp    (mem_rsp),
		.sd_buf     (sd_buf),
		.sd_buf_q   (sd_buf_q),
		.xfer_done  (xfer_done)
	);

endmodule

//--- source/bk_sequencer.sv
// ====================
// Load and save sequencer, one SD sector per step loop
// Load reads all 256 sectors, save writes sectors 0 to save_sz
// ====================
`timescale 1ns/1ps
`include "bk_macros.svh"

module bk_sequencer (
	input  logic                 clk_sys,
	input  logic                 arst_n,
	input  logic                 bk_load,    // Level, rising edge starts a load
	input  logic                 bk_save,    // Level, rising edge starts a save
	input  logic                 pending,
	input  logic [`BK_LBA_W-1:0] save_sz,
	input  logic                 sd_ack,
	output bk_pkg::sd_cmd_t      sd_cmd,
	output logic                 xfer_start,
	output bk_pkg::bk_mode_e     mode,
	input  logic                 xfer_done,
	output logic                 busy
);
	import bk_pkg::*;

	sd_cmd_t  cmd_q;
	bk_mode_e mode_q;
	bk_step_e step_q;
	logic     ack_q;
	logic     ack_rise;
	logic     ack_fall;
	logic     load_q;
	logic     save_q;
	logic     load_go; // Registered start edges
	logic     save_go;
	logic     size_ok;

	assign ack_rise = sd_ack & ~ack_q;
	assign ack_fall = ack_q & ~sd_ack; // Host finished the sector
	assign size_ok  = |save_sz;        // Nothing tracked, nothing to move

	assign sd_cmd = cmd_q;
	assign mode   = mode_q;
	assign busy   = (mode_q != mode_idle);

	// ====================
	// Edge detect
	// ====================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			ack_q   <= 1'b0;
			load_q  <= 1'b0;
			save_q  <= 1'b0;
			load_go <= 1'b0;
			save_go <= 1'b0;
		end else begin
			ack_q   <= sd_ack;
			load_q  <= bk_load;
			save_q  <= bk_save;
			load_go <= bk_load & ~load_q;
			save_go <= bk_save & ~save_q;
		end
	end

	// ====================
	// Sector loop
	// ====================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			cmd_q      <= '0;
			mode_q     <= mode_idle;
			step_q     <= step_start;
			xfer_start <= 1'b0;
		end else begin
			// Request levels drop once the host takes them
			if (ack_rise) begin
				cmd_q.rd <= 1'b0;
				cmd_q.wr <= 1'b0;
			end

			case (mode_q)
				mode_idle: begin
					xfer_start <= 1'b0;
					step_q     <= step_start;
					cmd_q.lba  <= '0;
					if (load_go && size_ok)
						mode_q <= mode_load;
					else if (save_go && pending && size_ok)
						mode_q <= mode_save; // Only when a save write happened
				end

				// SD read, then buffer to SDRAM
				mode_load: begin
					case (step_q)
						step_start: begin
							cmd_q.rd <= 1'b1;
							step_q   <= step_wait;
						end
						step_wait: if (ack_fall) begin
							xfer_start <= 1'b1; // Sector is in the buffer
							step_q     <= step_finish;
						end
						step_finish: if (xfer_done) begin
							xfer_start <= 1'b0;
							step_q     <= step_start;
							cmd_q.lba  <= cmd_q.lba + 1'b1;
							if (&cmd_q.lba)
								mode_q <= mode_idle; // Always the full 256 sectors
						end
						default: step_q <= step_start;
					endcase
				end

				// SDRAM to buffer, then SD write
				mode_save: begin
					case (step_q)
						step_start: begin
							xfer_start <= 1'b1;
							step_q     <= step_wait;
						end
						step_wait: if (xfer_done) begin
							xfer_start <= 1'b0;
							cmd_q.wr   <= 1'b1;
							step_q     <= step_finish;
						end
						step_finish: if (ack_fall) begin
							step_q    <= step_start;
							cmd_q.lba <= cmd_q.lba + 1'b1;
							if (cmd_q.lba == save_sz)
								mode_q <= mode_idle; // Last tracked sector written
						end
						default: step_q <= step_start;
					endcase
				end

				default: mode_q <= mode_idle;
			endcase
		end
	end

endmodule

//--- source/bk_block_mover.sv
// ====================
// Moves one sector between the buffer and SDRAM, one word per request
// ====================
`timescale 1ns/1ps
`include "bk_macros.svh"

module bk_block_mover (
	input  logic                  clk_sys,
	input  logic                  arst_n,
	input  logic                  xfer_start, // Low clears the mover
	input  bk_pkg::bk_mode_e      mode,
	input  logic [`BK_LBA_W-1:0]  lba,
	output bk_pkg::mem_req_t      mem_req,
	input  bk_pkg::mem_rsp_t      mem_rsp,
	input  bk_pkg::sd_buf_t       sd_buf,
	output logic [`BK_WORD_W-1:0] sd_buf_q,
	output logic                  xfer_done
);
	import bk_pkg::*;

	logic [`BK_WADDR_W-1:0] waddr;
	logic                   waiting; // Request out, ready not yet seen
	logic                   req_q;
	logic                   saving;
	logic                   buf_we;
	logic [`BK_WORD_W-1:0]  buf_q;

	assign saving = (mode == mode_save);
	assign buf_we = saving & waiting & mem_rsp.ready; // Returned word lands on ready

	// Read data settles while waddr is held, so din is valid at req
	assign mem_req = '{addr: {lba, waddr}, din: buf_q, req: req_q, rnw: saving};

	bk_buffer_ram i_bk_buffer_ram (
		.clk_sys  (clk_sys),
		.addr_a   (waddr),
		.din_a    (mem_rsp.dout),
		.we_a     (buf_we),
		.q_a      (buf_q),
		.sd_buf   (sd_buf),
		.sd_buf_q (sd_buf_q)
	);

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			waddr     <= '0;
			waiting   <= 1'b0;
			req_q     <= 1'b0;
			xfer_done <= 1'b0;
		end else begin
			req_q <= 1'b0;
			if (!xfer_start) begin
				waddr     <= '0;
				waiting   <= 1'b0;
				xfer_done <= 1'b0;
			end else if (!xfer_done) begin
				if (!waiting) begin
					req_q   <= 1'b1; // Issue, then wait for ready
					waiting <= 1'b1;
				end else if (mem_rsp.ready) begin
					waiting <= 1'b0;
					if (&waddr)
						xfer_done <= 1'b1; // 256th ready, held until start drops
					else
						waddr <= waddr + 1'b1;
				end
			end
		end
	end

endmodule

//--- source/bk_buffer_ram.sv
// ====================
// 256 x 16 sector buffer, port A for SDRAM moves, port B for the SD host
// ====================
`timescale 1ns/1ps
`include "bk_macros.svh"

module bk_buffer_ram (
	input  logic                   clk_sys,
	input  logic [`BK_WADDR_W-1:0] addr_a,
	input  logic [`BK_WORD_W-1:0]  din_a,
	input  logic                   we_a,
	output logic [`BK_WORD_W-1:0]  q_a,
	input  bk_pkg::sd_buf_t        sd_buf,
	output logic [`BK_WORD_W-1:0]  sd_buf_q
);

	localparam int DEPTH = 1 << `BK_WADDR_W;

	logic [`BK_WORD_W-1:0] mem [DEPTH];

	// ====================
	// Both ports
	// ====================
	// Same word written on both ports in one cycle is undefined
	always_ff @(posedge clk_sys) begin
		if (we_a)
			mem[addr_a] <= din_a;
		if (sd_buf.wr)
			mem[sd_buf.addr] <= sd_buf.din; // Host side sector data

		// Registered reads, old data on a same cycle write
		q_a      <= mem[addr_a];
		sd_buf_q <= mem[sd_buf.addr];
	end

endmodule

//--- source/bk_save_tracker.sv
// ====================
// Tracks the highest save sector written by the cartridge
// Also holds the save pending flag until a sequence runs
// ====================
`timescale 1ns/1ps
`include "bk_macros.svh"

module bk_save_tracker (
	input  logic                 clk_sys,
	input  logic                 arst_n,
	input  bk_pkg::save_kind_t   save_kind, // Active save type strobes
	input  logic                 bus_req,   // One cycle per bus access
	input  logic                 flash_1m,
	input  logic                 cart_load,
	input  logic                 busy,
	output logic [`BK_LBA_W-1:0] save_sz,   // Last sector to save
	output logic                 pending
);

	logic                 cart_load_q;
	logic                 cart_rise;
	logic                 save_write;
	logic [`BK_LBA_W-1:0] size_mask;

	assign cart_rise  = cart_load & ~cart_load_q; // New cartridge, forget old size
	assign save_write = bus_req & (|save_kind);

	// Union of the masks of all active kinds
	always_comb begin
		size_mask = '0;
		if (save_kind.eeprom)
			size_mask = size_mask | `BK_SZ_EEPROM;
		if (save_kind.sram)
			size_mask = size_mask | `BK_SZ_SRAM;
		if (save_kind.flash)
			size_mask = size_mask | `BK_SZ_FLASH | {flash_1m, {(`BK_LBA_W-1){1'b0}}};
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			cart_load_q <= 1'b0;
			save_sz     <= '0;
			pending     <= 1'b0;
		end else begin
			cart_load_q <= cart_load;

			if (cart_rise)
				save_sz <= '0;
			else if (bus_req)
				save_sz <= save_sz | size_mask; // Size only grows

			// A write during a sequence keeps it pending
			if (save_write)
				pending <= 1'b1;
			else if (busy)
				pending <= 1'b0;
		end
	end

endmodule

//--- source/bk_pkg.sv
// ====================
// Shared types of the backup RAM engine
// ====================
`include "bk_macros.svh"

package bk_pkg;

	// Engine mode, also selects the SDRAM direction
	typedef enum logic [1:0] {
		mode_idle,
		mode_load,
		mode_save
	} bk_mode_e;

	// Step within one sector
	typedef enum logic [1:0] {
		step_start,
		step_wait,
		step_finish
	} bk_step_e;

	// Save write strobes from the cartridge bus
	typedef struct packed {
		logic eeprom;
		logic sram;
		logic flash;
	} save_kind_t;

	// SD sector command
	typedef struct packed {
		logic [`BK_LBA_W-1:0] lba;
		logic                 rd; // Held until ack rises
		logic                 wr;
	} sd_cmd_t;

	// SD host side of the sector buffer
	typedef struct packed {
		logic [`BK_WADDR_W-1:0] addr;
		logic [`BK_WORD_W-1:0]  din;
		logic                   wr;
	} sd_buf_t;

	typedef struct packed {
		logic [`BK_MEM_ADDR_W-1:0] addr;
		logic [`BK_WORD_W-1:0]     din;
		logic                      req; // One cycle strobe
		logic                      rnw; // High reads SDRAM
	} mem_req_t;

	typedef struct packed {
		logic [`BK_WORD_W-1:0] dout;
		logic                  ready; // One cycle, ends a request
	} mem_rsp_t;

endpackage

//--- source/bk_macros.svh
// ====================
// Widths and save size masks of the backup RAM engine
// Included by the package, the RTL and the bench
// ====================
`ifndef BK_MACROS_SVH
`define BK_MACROS_SVH

// ====================
// Data path widths
// ====================
`define BK_WORD_W      16 // One buffer word
`define BK_WADDR_W     8  // Word index, 256 words per sector
`define BK_LBA_W       8  // Sector number, 256 sectors
`define BK_MEM_ADDR_W  16 // SDRAM word address, sector then word

// ====================
// Save size masks
// ====================
// Highest sector used by each save type, ORed into the tracked size
`define BK_SZ_EEPROM   8'd15
`define BK_SZ_SRAM     8'd63
`define BK_SZ_FLASH    8'd127 // 1M Flash adds the top bit

`endif
